//--- source/mv_macros.svh
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// widths, depths and register map of the
// matrix-vector engine
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`ifndef MV_MACROS_SVH
`define MV_MACROS_SVH

`define MV_AW           10   // scratchpad word address
`define MV_CW           10   // row and column counters
`define MV_RES_DEPTH    4    // result queue, also initial credits

`define MV_REG_WBASE    6'h00
`define MV_REG_IBASE    6'h01
`define MV_REG_BBASE    6'h02
`define MV_REG_OBASE    6'h03
`define MV_REG_ILEN     6'h04
`define MV_REG_OLEN     6'h05
`define MV_REG_WSTRIDE  6'h06

`define MV_REG_RUN      6'h20
`define MV_REG_STATE    6'h21
`define MV_REG_TIME     6'h22
`define MV_REG_CHECK    6'h3F

`define MV_CHECK_WORD   32'hF0F0_F0F0

`endif

//--- source/mv_pkg.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// opcode and decode state enums
// job parameter, op and result structs
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none
`include "mv_macros.svh"

package mv_pkg;

    typedef enum logic [1:0] {
        OP_NONE     = 2'd0,
        OP_BIAS     = 2'd1,
        OP_MAC      = 2'd2,
        OP_MAC_LAST = 2'd3   // closes a row
    } mv_opcode_t;

    typedef enum logic [1:0] {
        ST_IDLE = 2'd0,
        ST_BIAS = 2'd1,
        ST_MAC  = 2'd2,
        ST_WAIT = 2'd3
    } mv_state_t;

    typedef struct packed {
        logic [`MV_AW-1:0] wbase;
        logic [`MV_AW-1:0] ibase;
        logic [`MV_AW-1:0] bbase;
        logic [`MV_AW-1:0] obase;
        logic [`MV_CW-1:0] ilen;     // columns
        logic [`MV_CW-1:0] olen;     // rows
        logic [`MV_CW-1:0] wstride;
    } mv_params_t;

    typedef struct packed {
        mv_opcode_t opcode;
        logic       last_row;
    } mv_op_t;

    typedef struct packed {
        logic [`MV_AW-1:0] addr;
        logic [31:0]       sum;
        logic              last_row;
    } mv_result_t;

endpackage

`default_nettype wire

//--- source/mv_config.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// host registers, run edge detect,
// status bits and cycle counter
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ns
`default_nettype none
`include "mv_macros.svh"

module mv_config (
    input  wire                 clk,
    input  wire                 rst,
    input  wire                 config_ena,
    input  wire  [5:0]          config_addr,
    input  wire  [31:0]         config_wdata,
    output logic [31:0]         config_rdata,
    output mv_pkg::mv_params_t  params,
    output logic                start,
    input  wire                 over_pulse
);

    logic [1:0]  run;        // [1] is last cycle's copy
    logic        running;
    logic        over;
    logic [31:0] time_cnt;

    // job parameters keep their value through reset
    always_ff @(posedge clk) begin
        if (config_ena) begin
            case (config_addr)
                `MV_REG_WBASE:   params.wbase   <= config_wdata[`MV_AW-1:0];
                `MV_REG_IBASE:   params.ibase   <= config_wdata[`MV_AW-1:0];
                `MV_REG_BBASE:   params.bbase   <= config_wdata[`MV_AW-1:0];
                `MV_REG_OBASE:   params.obase   <= config_wdata[`MV_AW-1:0];
                `MV_REG_ILEN:    params.ilen    <= config_wdata[`MV_CW-1:0];
                `MV_REG_OLEN:    params.olen    <= config_wdata[`MV_CW-1:0];
                `MV_REG_WSTRIDE: params.wstride <= config_wdata[`MV_CW-1:0];
                default: ;
            endcase
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            run <= 2'b00;
        end else begin
            run[1] <= run[0];
            if (config_ena && config_addr == `MV_REG_RUN)
                run[0] <= config_wdata[0];
        end
    end

    assign start = run[0] & ~run[1];   // 0 -> 1 only

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            running  <= 1'b0;
            over     <= 1'b0;
            time_cnt <= '0;
        end else if (start) begin
            running  <= 1'b1;
            over     <= 1'b0;
            time_cnt <= '0;
        end else begin
            if (over_pulse) begin
                running <= 1'b0;
                over    <= 1'b1;
            end
            if (running && time_cnt != '1)   // saturate
                time_cnt <= time_cnt + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        case (config_addr)
            `MV_REG_WBASE:   config_rdata <= 32'(params.wbase);
            `MV_REG_IBASE:   config_rdata <= 32'(params.ibase);
            `MV_REG_BBASE:   config_rdata <= 32'(params.bbase);
            `MV_REG_OBASE:   config_rdata <= 32'(params.obase);
            `MV_REG_ILEN:    config_rdata <= 32'(params.ilen);
            `MV_REG_OLEN:    config_rdata <= 32'(params.olen);
            `MV_REG_WSTRIDE: config_rdata <= 32'(params.wstride);
            `MV_REG_RUN:     config_rdata <= 32'(run[0]);
            `MV_REG_STATE:   config_rdata <= {30'd0, running, over};
            `MV_REG_TIME:    config_rdata <= time_cnt;
            `MV_REG_CHECK:   config_rdata <= `MV_CHECK_WORD;
            default:         config_rdata <= '0;
        endcase
    end

endmodule

`default_nettype wire

//--- source/mv_scratchpad.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// scratchpad words, host port, two
// engine read ports, shared write port
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ns
`default_nettype none
`include "mv_macros.svh"

module mv_scratchpad (
    input  wire                 clk,
    input  wire                 mem_ena,
    input  wire                 mem_we,
    input  wire  [`MV_AW-1:0]   mem_addr,
    input  wire  [31:0]         mem_wdata,
    output logic [31:0]         mem_rdata,
    input  wire  [`MV_AW-1:0]   rd_addr_a,
    output logic [31:0]         rd_data_a,
    input  wire  [`MV_AW-1:0]   rd_addr_b,
    output logic [31:0]         rd_data_b,
    input  wire                 wr_req,
    input  wire  [`MV_AW-1:0]   wr_addr,
    input  wire  [31:0]         wr_data,
    output logic                wr_grant
);

    logic [31:0] mem [2**`MV_AW];
    logic        host_wr;

    assign host_wr  = mem_ena & mem_we;
    assign wr_grant = wr_req & ~host_wr;   // host always wins

    always_ff @(posedge clk) begin
        if (host_wr)
            mem[mem_addr] <= mem_wdata;
        else if (wr_grant)
            mem[wr_addr] <= wr_data;

        if (mem_ena && !mem_we)
            mem_rdata <= mem[mem_addr];
        rd_data_a <= mem[rd_addr_a];
        rd_data_b <= mem[rd_addr_b];
    end

endmodule

`default_nettype wire

//--- source/mv_decode.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// row and column walker, operand reads,
// op issue and result credits
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ns
`default_nettype none
`include "mv_macros.svh"

module mv_decode (
    input  wire                 clk,
    input  wire                 rst,
    input  wire                 start,
    input  wire mv_pkg::mv_params_t params,
    output logic [`MV_AW-1:0]   rd_addr_a,
    output logic [`MV_AW-1:0]   rd_addr_b,
    output mv_pkg::mv_op_t      op,
    output logic                op_valid,
    input  wire                 credit_return
);

    localparam int CRW = $clog2(`MV_RES_DEPTH + 1);

    mv_pkg::mv_state_t   state;
    mv_pkg::mv_op_t      issue_op;
    logic [`MV_CW-1:0]   row;
    logic [`MV_CW-1:0]   col;
    logic [`MV_AW-1:0]   row_base;   // wbase + row*wstride
    logic [CRW-1:0]      credits;
    logic                issue;
    logic                spend;
    logic                last_col;
    logic                last_row;

    assign last_col = (col == params.ilen - 1'b1);
    assign last_row = (row == params.olen - 1'b1);
    assign spend    = issue && issue_op.opcode == mv_pkg::OP_BIAS;

    always_comb begin
        issue             = 1'b0;
        issue_op.opcode   = mv_pkg::OP_NONE;
        issue_op.last_row = last_row;
        rd_addr_a         = row_base + `MV_AW'(col);       // weight
        rd_addr_b         = params.ibase + `MV_AW'(col);   // input
        case (state)
            mv_pkg::ST_BIAS: begin
                rd_addr_a = params.bbase + `MV_AW'(row);
                if (credits != '0) begin
                    issue           = 1'b1;
                    issue_op.opcode = mv_pkg::OP_BIAS;
                end
            end
            mv_pkg::ST_MAC: begin
                issue = 1'b1;
                if (last_col)
                    issue_op.opcode = mv_pkg::OP_MAC_LAST;
                else
                    issue_op.opcode = mv_pkg::OP_MAC;
            end
            default: ;
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state    <= mv_pkg::ST_IDLE;
            credits  <= CRW'(`MV_RES_DEPTH);
            op_valid <= 1'b0;
            row      <= '0;
            col      <= '0;
            row_base <= '0;
        end else begin
            op_valid <= issue;
            credits  <= credits + CRW'(credit_return) - CRW'(spend);
            case (state)
                mv_pkg::ST_IDLE: if (start) begin
                    state    <= mv_pkg::ST_BIAS;
                    row      <= '0;
                    col      <= '0;
                    row_base <= params.wbase;
                end
                mv_pkg::ST_BIAS: if (issue) state <= mv_pkg::ST_MAC;
                mv_pkg::ST_MAC: begin
                    if (last_col) begin
                        col      <= '0;
                        row      <= row + 1'b1;
                        row_base <= row_base + `MV_AW'(params.wstride);
                        state    <= last_row ? mv_pkg::ST_WAIT : mv_pkg::ST_BIAS;
                    end else begin
                        col <= col + 1'b1;
                    end
                end
                // drain until every queued row is written
                mv_pkg::ST_WAIT: if (credits == CRW'(`MV_RES_DEPTH)) state <= mv_pkg::ST_IDLE;
                default: state <= mv_pkg::ST_IDLE;
            endcase
        end
    end

    // lines up with the registered read data
    always_ff @(posedge clk) begin
        op <= issue_op;
    end

endmodule

`default_nettype wire

//--- source/mv_execute.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// signed multiply-accumulate, one
// result per row
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ns
`default_nettype none
`include "mv_macros.svh"

module mv_execute (
    input  wire                 clk,
    input  wire                 rst,
    input  wire mv_pkg::mv_op_t op,
    input  wire                 op_valid,
    input  wire  [31:0]         rd_data_a,
    input  wire  [31:0]         rd_data_b,
    input  wire  [`MV_AW-1:0]   obase,
    output mv_pkg::mv_result_t  res,
    output logic                res_valid
);

    logic signed [31:0] product;
    logic [31:0]        acc;
    logic [31:0]        acc_next;
    logic [`MV_AW-1:0]  row_addr;   // output word of current row
    logic               in_job;

    assign product  = $signed(rd_data_a[15:0]) * $signed(rd_data_b[15:0]);
    assign acc_next = acc + $unsigned(product);   // wraps at 32 bits

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            res_valid <= 1'b0;
            in_job    <= 1'b0;
        end else begin
            res_valid <= op_valid && op.opcode == mv_pkg::OP_MAC_LAST;
            if (op_valid && op.opcode == mv_pkg::OP_BIAS)
                in_job <= 1'b1;
            else if (op_valid && op.opcode == mv_pkg::OP_MAC_LAST && op.last_row)
                in_job <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (op_valid) begin
            case (op.opcode)
                mv_pkg::OP_BIAS: begin
                    acc <= rd_data_a;
                    if (!in_job)
                        row_addr <= obase;   // first row of a job
                end
                mv_pkg::OP_MAC: acc <= acc_next;
                mv_pkg::OP_MAC_LAST: begin
                    res.addr     <= row_addr;
                    res.sum      <= acc_next;
                    res.last_row <= op.last_row;
                    row_addr     <= row_addr + 1'b1;
                end
                default: ;
            endcase
        end
    end

endmodule

`default_nettype wire

//--- source/mv_result.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// result queue, writeback, credit
// return and job-over pulse
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ns
`default_nettype none
`include "mv_macros.svh"

module mv_result (
    input  wire                 clk,
    input  wire                 rst,
    input  wire mv_pkg::mv_result_t res,
    input  wire                 res_valid,
    output logic                wr_req,
    output logic [`MV_AW-1:0]   wr_addr,
    output logic [31:0]         wr_data,
    input  wire                 wr_grant,
    output logic                credit_return,
    output logic                over_pulse
);

    localparam int PW = $clog2(`MV_RES_DEPTH);

    mv_pkg::mv_result_t queue [`MV_RES_DEPTH];
    logic [PW-1:0]      wr_ptr;
    logic [PW-1:0]      rd_ptr;
    logic [PW:0]        count;
    logic               pop;

    // no full check, decode credits keep count <= depth
    assign wr_req        = (count != '0);
    assign wr_addr       = queue[rd_ptr].addr;
    assign wr_data       = queue[rd_ptr].sum;
    assign pop           = wr_req & wr_grant;
    assign credit_return = pop;

    always_ff @(posedge clk) begin
        if (res_valid)
            queue[wr_ptr] <= res;
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            wr_ptr     <= '0;
            rd_ptr     <= '0;
            count      <= '0;
            over_pulse <= 1'b0;
        end else begin
            if (res_valid)
                wr_ptr <= wr_ptr + 1'b1;
            if (pop)
                rd_ptr <= rd_ptr + 1'b1;
            count      <= count + (PW+1)'(res_valid) - (PW+1)'(pop);
            over_pulse <= pop && queue[rd_ptr].last_row;   // last row landed
        end
    end

endmodule

`default_nettype wire

//--- source/mv_top.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// matrix-vector accelerator top
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ns
`default_nettype none
`include "mv_macros.svh"

module mv_top (
    input  wire                 clk,
    input  wire                 rst,
    input  wire                 config_ena,
    input  wire  [5:0]          config_addr,
    input  wire  [31:0]         config_wdata,
    output logic [31:0]         config_rdata,
    input  wire                 mem_ena,
    input  wire                 mem_we,
    input  wire  [`MV_AW-1:0]   mem_addr,
    input  wire  [31:0]         mem_wdata,
    output logic [31:0]         mem_rdata
);

    mv_pkg::mv_params_t  params;
    mv_pkg::mv_op_t      op;
    mv_pkg::mv_result_t  res;
    logic                start;
    logic                over_pulse;
    logic                op_valid;
    logic                res_valid;
    logic                credit_return;
    logic [`MV_AW-1:0]   rd_addr_a;
    logic [`MV_AW-1:0]   rd_addr_b;
    logic [31:0]         rd_data_a;
    logic [31:0]         rd_data_b;
    logic                wr_req;
    logic                wr_grant;
    logic [`MV_AW-1:0]   wr_addr;
    logic [31:0]         wr_data;

    mv_config u_config (
        .clk(clk), .rst(rst),
        .config_ena(config_ena), .config_addr(config_addr),
        .config_wdata(config_wdata), .config_rdata(config_rdata),
        .params(params), .start(start), .over_pulse(over_pulse)
    );

    mv_scratchpad u_scratchpad (
        .clk(clk),
        .mem_ena(mem_ena), .mem_we(mem_we), .mem_addr(mem_addr),
        .mem_wdata(mem_wdata), .mem_rdata(mem_rdata),
        .rd_addr_a(rd_addr_a), .rd_data_a(rd_data_a),
        .rd_addr_b(rd_addr_b), .rd_data_b(rd_data_b),
        .wr_req(wr_req), .wr_addr(wr_addr), .wr_data(wr_data), .wr_grant(wr_grant)
    );

    mv_decode u_decode (
        .clk(clk), .rst(rst), .start(start), .params(params),
        .rd_addr_a(rd_addr_a), .rd_addr_b(rd_addr_b),
        .op(op), .op_valid(op_valid), .credit_return(credit_return)
    );

    mv_execute u_execute (
        .clk(clk), .rst(rst), .op(op), .op_valid(op_valid),
        .rd_data_a(rd_data_a), .rd_data_b(rd_data_b), .obase(params.obase),
        .res(res), .res_valid(res_valid)
    );

    mv_result u_result (
        .clk(clk), .rst(rst), .res(res), .res_valid(res_valid),
        .wr_req(wr_req), .wr_addr(wr_addr), .wr_data(wr_data), .wr_grant(wr_grant),
        .credit_return(credit_return), .over_pulse(over_pulse)
    );

endmodule

`default_nettype wire

//--- testbench/tb_clock.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// free running testbench clock
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ns
`default_nettype none

module tb_clock #(
    parameter int PERIOD = 100
) (
    output logic clk
);

    initial clk = 1'b0;
    always #(PERIOD / 2) clk = ~clk;

endmodule

`default_nettype wire

//--- testbench/tb_mv_top.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// testbench for mv_top with register, job,
// back-pressure and rerun tests and a watchdog
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ns
`default_nettype none
`include "mv_macros.svh"

module tb_mv_top;

    localparam int WBASE      = 'h100;
    localparam int IBASE      = 'h040;
    localparam int BBASE      = 'h060;
    localparam int OBASE      = 'h080;
    localparam int NOISE_BASE = 'h300;   // host traffic area clear of every job
    localparam int NUM_TESTS  = 6;
    localparam int MAX_OPS    = 8 * 5;   // largest olen*ilen
    localparam int WATCHDOG_CYCLES = NUM_TESTS * (MAX_OPS * 20 + 1000);

    logic              clk;
    logic              rst;
    logic              config_ena;
    logic [5:0]        config_addr;
    logic [31:0]       config_wdata;
    logic [31:0]       config_rdata;
    logic              mem_ena;
    logic              mem_we;
    logic [`MV_AW-1:0] mem_addr;
    logic [31:0]       mem_wdata;
    logic [31:0]       mem_rdata;

    logic [31:0] wmat [16][16];
    logic [31:0] ivec [16];
    logic [31:0] bvec [16];
    int          n_rows;
    int          n_cols;
    int          errors = 0;
    int          checks = 0;
    int          tests = 0;
    int          failed = 0;
    int          test_start = 0;
    logic [31:0] rng = 32'd15414;
    bit          job_done;

    tb_clock #(.PERIOD(100)) u_clock (.clk(clk));

    mv_top UUT (
        .clk(clk), .rst(rst),
        .config_ena(config_ena), .config_addr(config_addr),
        .config_wdata(config_wdata), .config_rdata(config_rdata),
        .mem_ena(mem_ena), .mem_we(mem_we), .mem_addr(mem_addr),
        .mem_wdata(mem_wdata), .mem_rdata(mem_rdata)
    );

    function automatic logic [31:0] next_rand();
        rng = rng ^ (rng << 13);
        rng = rng ^ (rng >> 17);
        rng = rng ^ (rng << 5);
        return rng;
    endfunction

    // bias plus signed 16x16 products with 32-bit wrap
    function automatic logic [31:0] mv_ref(input int r);
        int acc;
        int p;
        acc = bvec[r];
        for (int c = 0; c < n_cols; c++) begin
            p = 32'($signed(wmat[r][c][15:0])) * 32'($signed(ivec[c][15:0]));
            acc = acc + p;
        end
        return acc;
    endfunction

    task automatic cfg_write(input logic [5:0] addr, input logic [31:0] data);
        @(posedge clk);
        config_ena   <= 1'b1;
        config_addr  <= addr;
        config_wdata <= data;
        @(posedge clk);
        config_ena   <= 1'b0;
    endtask

    task automatic cfg_read(input logic [5:0] addr, output logic [31:0] data);
        @(posedge clk);
        config_addr <= addr;
        repeat (2) @(posedge clk);   // readback is registered
        data = config_rdata;
    endtask

    task automatic mem_write(input int addr, input logic [31:0] data);
        @(posedge clk);
        mem_ena   <= 1'b1;
        mem_we    <= 1'b1;
        mem_addr  <= `MV_AW'(addr);
        mem_wdata <= data;
        @(posedge clk);
        mem_ena   <= 1'b0;
        mem_we    <= 1'b0;
    endtask

    task automatic mem_read(input int addr, output logic [31:0] data);
        @(posedge clk);
        mem_ena  <= 1'b1;
        mem_we   <= 1'b0;
        mem_addr <= `MV_AW'(addr);
        @(posedge clk);
        mem_ena  <= 1'b0;
        @(posedge clk);
        data = mem_rdata;
    endtask

    task automatic check_word(input string name, input logic [31:0] exp,
                              input logic [31:0] act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("** Error %s: expected %h, actual %h", name, exp, act);
        end
    endtask

    task automatic check_state(input string name, input logic [1:0] exp,
                               input logic [1:0] act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("** Error %s: expected running,over %b, actual %b", name, exp, act);
        end
    endtask

    task automatic expect_true(input bit cond, input string what);
        checks++;
        if (!cond) begin
            errors++;
            $display("%s", what);
        end
    endtask

    task automatic end_test(input string name);
        tests++;
        if (errors == test_start) begin
            $display("test %s: ok", name);
        end else begin
            failed++;
            $display("test %s: %0d errors", name, errors - test_start);
        end
        test_start = errors;
    endtask

    // fills operands in the scratchpad and programs the job registers
    task automatic load_job(input int rows, input int cols, input int stride);
        n_rows = rows;
        n_cols = cols;
        for (int r = 0; r < rows; r++) begin
            bvec[r] = next_rand();
            mem_write(BBASE + r, bvec[r]);
        end
        for (int c = 0; c < cols; c++) begin
            ivec[c] = next_rand();
            mem_write(IBASE + c, ivec[c]);
        end
        for (int r = 0; r < rows; r++) begin
            for (int c = 0; c < cols; c++) begin
                wmat[r][c] = next_rand();
                mem_write(WBASE + r * stride + c, wmat[r][c]);
            end
        end
        cfg_write(`MV_REG_WBASE, WBASE);
        cfg_write(`MV_REG_IBASE, IBASE);
        cfg_write(`MV_REG_BBASE, BBASE);
        cfg_write(`MV_REG_OBASE, OBASE);
        cfg_write(`MV_REG_ILEN, cols);
        cfg_write(`MV_REG_OLEN, rows);
        cfg_write(`MV_REG_WSTRIDE, stride);
    endtask

    task automatic start_job();
        cfg_write(`MV_REG_RUN, 32'd0);
        cfg_write(`MV_REG_RUN, 32'd1);
    endtask

    task automatic wait_over();
        logic [31:0] st;
        st = '0;
        while (st[0] !== 1'b1)
            cfg_read(`MV_REG_STATE, st);
    endtask

    task automatic check_outputs(input string name);
        logic [31:0] rd;
        for (int r = 0; r < n_rows; r++) begin
            mem_read(OBASE + r, rd);
            check_word($sformatf("%s row %0d", name, r), mv_ref(r), rd);
        end
    endtask

    // host holds the write port 15 cycles in 16 so the result queue fills
    task automatic host_noise();
        logic [31:0] r;
        int          n;
        n = 0;
        while (!job_done) begin
            @(posedge clk);
            r = next_rand();
            mem_ena   <= (n % 16 != 15);
            mem_we    <= (n % 16 != 15);
            mem_addr  <= `MV_AW'(NOISE_BASE + int'(r[13:8]));
            mem_wdata <= r;
            n++;
        end
        mem_ena <= 1'b0;
        mem_we  <= 1'b0;
    endtask

    initial begin
        logic [31:0] rd;
        logic [31:0] v;
        logic [31:0] old_exp [16];
        int          w;
        rst          <= 1'b1;
        config_ena   <= 1'b0;
        config_addr  <= '0;
        config_wdata <= '0;
        mem_ena      <= 1'b0;
        mem_we       <= 1'b0;
        mem_addr     <= '0;
        mem_wdata    <= '0;
        repeat (10) @(posedge clk);
        rst <= 1'b0;

        cfg_read(`MV_REG_STATE, rd);
        check_word("reset state", 32'd0, rd);
        cfg_read(`MV_REG_TIME, rd);
        check_word("reset time", 32'd0, rd);
        cfg_read(`MV_REG_CHECK, rd);
        check_word("check word", `MV_CHECK_WORD, rd);
        end_test("reset_values");

        for (int a = 0; a < 7; a++) begin
            v = next_rand();
            w = (a < 4) ? `MV_AW : `MV_CW;   // addresses then counts
            cfg_write(6'(a), v);
            cfg_read(6'(a), rd);
            check_word($sformatf("param reg %0d", a), v & ((32'd1 << w) - 32'd1), rd);
        end
        end_test("param_readback");

        load_job(4, 6, 9);
        start_job();
        wait_over();
        check_outputs("job_4x6");
        cfg_read(`MV_REG_STATE, rd);
        check_state("job_4x6 state", 2'b01, rd[1:0]);
        end_test("job_4x6");

        load_job(8, 5, 7);
        job_done = 1'b0;
        start_job();
        fork
            begin
                wait_over();
                job_done = 1'b1;
            end
            host_noise();
        join
        check_outputs("job_8x5_busy");
        end_test("job_8x5_busy");

        // new biases must not show up unless a real run edge happens
        for (int r = 0; r < n_rows; r++) begin
            old_exp[r] = mv_ref(r);
            bvec[r] = next_rand();
            mem_write(BBASE + r, bvec[r]);
        end
        cfg_write(`MV_REG_RUN, 32'd1);
        repeat (200) @(posedge clk);
        cfg_read(`MV_REG_STATE, rd);
        check_state("run held high state", 2'b01, rd[1:0]);
        for (int r = 0; r < n_rows; r++) begin
            mem_read(OBASE + r, rd);
            check_word($sformatf("run held high row %0d", r), old_exp[r], rd);
        end
        start_job();
        cfg_read(`MV_REG_STATE, rd);
        check_state("rerun state", 2'b10, rd[1:0]);
        cfg_read(`MV_REG_TIME, rd);
        // only two register reads since the start
        expect_true(rd < 32'd16, "time counter did not restart on the new run");
        wait_over();
        check_outputs("rerun");
        cfg_read(`MV_REG_TIME, rd);
        expect_true(rd != 32'd0, "time counter reads zero after the rerun finished");
        end_test("rerun");

        load_job(1, 1, 1);
        start_job();
        wait_over();
        check_outputs("job_1x1");
        load_job(5, 1, 3);
        start_job();
        wait_over();
        check_outputs("job_5x1");
        cfg_read(`MV_REG_STATE, rd);
        check_state("job_5x1 state", 2'b01, rd[1:0]);
        end_test("single_column");

        $display("%0d tests, %0d failed, %0d checks, %0d errors",
                 tests, failed, checks, errors);
        if (errors == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("timeout: run did not finish within %0d clock cycles", WATCHDOG_CYCLES);
        $display("TESTS FAILED");
        $finish;
    end

endmodule

`default_nettype wire

//--- all.f
+incdir+source
source/mv_pkg.sv
source/mv_config.sv
source/mv_scratchpad.sv
source/mv_decode.sv
source/mv_execute.sv
source/mv_result.sv
source/mv_top.sv
testbench/tb_clock.sv
testbench/tb_mv_top.sv

//--- Makefile
# Verilator build and run for the matrix-vector accelerator

VERILATOR ?= verilator
TOP       ?= tb_mv_top
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
FILELIST  ?= all.f
VFLAGS    ?= --binary --timing -j 0

SOURCES := $(shell grep -v '^+' $(FILELIST))
HEADERS := $(wildcard source/*.svh)
BIN     := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(BIN): $(FILELIST) $(SOURCES) $(HEADERS)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)

run: $(BIN)
	./$(BIN) | tee $(LOG)
	@grep -q "TESTS PASSED" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
